// File: Bender.yml
package:
  name: plic_bridge

sources:
  - logic/plic_bridge_pkg.sv
  - logic/plic_addr_map.sv
  - logic/plic_bridge_fsm.sv
  - logic/plic_reg_file.sv
  - logic/plic_gateway.sv
  - logic/plic_target.sv
  - logic/plic_bridge_top.sv
  - target: simulation
    files:
      - verification/plic_bridge_tb.sv

// File: logic/plic_addr_map.sv
`default_nettype none

module plic_addr_map import plic_bridge_pkg::*; (
  input  wire reg_req_t reg_req_i,
  output reg_sel_t      reg_sel_o
);

  always_comb begin : p_decode
    reg_addr_t offset;
    reg_addr_t prio_idx;

    offset   = reg_req_i.addr - PlicBase[RegWidth-1:0];
    prio_idx = offset - PrioOffset;

    reg_sel_o.kind = KindNone;
    reg_sel_o.src  = '0;
    reg_sel_o.tgt  = '0;

    // one word per source priority
    if (offset >= PrioOffset && offset < PrioOffset + PrioStride * NumSources &&
        offset[1:0] == 2'b00) begin
      reg_sel_o.kind = KindPrio;
      reg_sel_o.src  = prio_idx[IdWidth+1:2];
    end else if (offset == PendOffset) begin
      reg_sel_o.kind = KindPend;
    end

    for (int unsigned t = 0; t < NumTargets; t++) begin
      if (offset == EnableOffset + EnableStride * t) begin
        reg_sel_o.kind = KindEnable;
        reg_sel_o.tgt  = t[TgtIdxWidth-1:0];
      end
      if (offset == ThreshOffset + ThreshStride * t) begin
        reg_sel_o.kind = KindThresh;
        reg_sel_o.tgt  = t[TgtIdxWidth-1:0];
      end
      if (offset == ClaimOffset + ThreshStride * t) begin
        reg_sel_o.kind = KindClaim;
        reg_sel_o.tgt  = t[TgtIdxWidth-1:0];
      end
    end

    reg_sel_o.we = reg_req_i.valid && reg_req_i.write;
    reg_sel_o.re = reg_req_i.valid && !reg_req_i.write;
  end

endmodule

`default_nettype wire

// File: logic/plic_bridge_fsm.sv
`default_nettype none

module plic_bridge_fsm import plic_bridge_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  // write address and data, always offered together
  input  wire logic     aw_valid_i,
  input  wire axil_aw_t aw_i,
  output logic          aw_ready_o,
  input  wire logic     w_valid_i,
  input  wire axil_w_t  w_i,
  output logic          w_ready_o,
  // write response
  output logic          b_valid_o,
  input  wire logic     b_ready_i,
  // read address
  input  wire logic     ar_valid_i,
  input  wire axil_aw_t ar_i,
  output logic          ar_ready_o,
  // read data
  output logic          r_valid_o,
  output axi_data_t     r_data_o,
  input  wire logic     r_ready_i,
  // register side
  input  wire reg_data_t rdata_i,
  output reg_req_t       reg_req_o
);

  bridge_state_e state_d, state_q;
  reg_data_t     rword_d, rword_q;
  reg_addr_t     addr_d, addr_q;
  reg_data_t     wdata_hi_d, wdata_hi_q;

  // only idle takes new requests
  assign aw_ready_o = (state_q == Idle);
  assign w_ready_o  = (state_q == Idle);
  assign ar_ready_o = (state_q == Idle);

  assign b_valid_o = (state_q == WriteSecond) || (state_q == WriteResp);
  assign r_valid_o = (state_q == ReadSecond) || (state_q == ReadResp);

  // low word captured at acceptance, high word is the live second read
  assign r_data_o = {rdata_i, rword_q};

  always_comb begin : p_next
    state_d    = state_q;
    rword_d    = rword_q;
    addr_d     = addr_q;
    wdata_hi_d = wdata_hi_q;

    // outside idle the register side looks at the second word
    reg_req_o.valid = 1'b0;
    reg_req_o.write = 1'b0;
    reg_req_o.addr  = addr_q + 32'd4;
    reg_req_o.wdata = wdata_hi_q;

    unique case (state_q)
      Idle: begin
        // write wins over a read offered in the same cycle
        if (aw_valid_i && w_valid_i) begin
          // a zero strobe skips both words
          reg_req_o.valid = |w_i.strb;
          reg_req_o.write = 1'b1;
          reg_req_o.addr  = aw_i.addr[RegWidth-1:0];
          reg_req_o.wdata = w_i.data[RegWidth-1:0];
          addr_d          = aw_i.addr[RegWidth-1:0];
          wdata_hi_d      = w_i.data[AxiDataWidth-1:RegWidth];
          state_d = ((aw_i.size == SizeDword) && (|w_i.strb)) ? WriteSecond : WriteResp;
        end else if (ar_valid_i) begin
          reg_req_o.valid = 1'b1;
          reg_req_o.addr  = ar_i.addr[RegWidth-1:0];
          addr_d          = ar_i.addr[RegWidth-1:0];
          rword_d         = rdata_i;
          state_d = (ar_i.size == SizeDword) ? ReadSecond : ReadResp;
        end
      end
      // high word goes out with the B handshake
      WriteSecond: begin
        if (b_ready_i) begin
          reg_req_o.valid = 1'b1;
          reg_req_o.write = 1'b1;
          state_d         = Idle;
        end
      end
      // high word read only once, so a claim fires once
      ReadSecond: begin
        if (r_ready_i) begin
          reg_req_o.valid = 1'b1;
          state_d         = Idle;
        end
      end
      WriteResp: begin
        if (b_ready_i) begin
          state_d = Idle;
        end
      end
      ReadResp: begin
        if (r_ready_i) begin
          state_d = Idle;
        end
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
    if (!rst_ni) begin
      state_q <= Idle;
      rword_q <= '0;
    end else begin
      state_q <= state_d;
      rword_q <= rword_d;
    end
  end

  // request payload for the second word
  always_ff @(posedge clk_i) begin : p_payload
    addr_q     <= addr_d;
    wdata_hi_q <= wdata_hi_d;
  end

endmodule

`default_nettype wire

// File: logic/plic_bridge_pkg.sv
`default_nettype none

package plic_bridge_pkg;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  localparam int unsigned AxiAddrWidth = 64;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned RegWidth     = 32;
  // id 0 means no interrupt
  localparam int unsigned NumSources   = 8;
  localparam int unsigned NumTargets   = 2;
  localparam int unsigned PrioWidth    = 3;
  localparam int unsigned IdWidth      = 3;
  localparam int unsigned TgtIdxWidth  = $clog2(NumTargets);

  localparam logic [63:0] PlicBase  = 64'hfff1100000;
  // 8 byte transfer
  localparam logic [2:0]  SizeDword = 3'd3;

  ////////////////////////////////////////////////////////////
  // register map offsets
  ////////////////////////////////////////////////////////////

  localparam logic [31:0] PrioOffset   = 32'h0000_0000;
  localparam logic [31:0] PrioStride   = 32'h0000_0004;
  localparam logic [31:0] PendOffset   = 32'h0000_1000;
  localparam logic [31:0] EnableOffset = 32'h0000_2000;
  localparam logic [31:0] EnableStride = 32'h0000_0080;
  localparam logic [31:0] ThreshOffset = 32'h0020_0000;
  localparam logic [31:0] ThreshStride = 32'h0000_1000;
  localparam logic [31:0] ClaimOffset  = ThreshOffset + 32'h0000_0004;

  typedef logic [AxiAddrWidth-1:0]   axi_addr_t;
  typedef logic [AxiDataWidth-1:0]   axi_data_t;
  typedef logic [AxiDataWidth/8-1:0] axi_strb_t;
  typedef logic [2:0]                axi_size_t;
  typedef logic [RegWidth-1:0]       reg_addr_t;
  typedef logic [RegWidth-1:0]       reg_data_t;
  typedef logic [PrioWidth-1:0]      prio_t;
  typedef logic [IdWidth-1:0]        irq_id_t;
  typedef logic [NumSources-1:0]     src_vec_t;
  typedef logic [2:0]                reg_kind_t;

  localparam reg_kind_t KindNone   = 3'd0;
  localparam reg_kind_t KindPrio   = 3'd1;
  localparam reg_kind_t KindPend   = 3'd2;
  localparam reg_kind_t KindEnable = 3'd3;
  localparam reg_kind_t KindThresh = 3'd4;
  localparam reg_kind_t KindClaim  = 3'd5;

  typedef struct packed {
    axi_addr_t addr;
    axi_size_t size;
  } axil_aw_t;

  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axil_w_t;

  typedef struct packed {
    logic      valid;
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    reg_kind_t              kind;
    irq_id_t                src;
    logic [TgtIdxWidth-1:0] tgt;
    logic                   we;
    logic                   re;
  } reg_sel_t;

  // one access per cycle, so a single id per pulse kind is enough
  typedef struct packed {
    logic [NumTargets-1:0] claim_valid;
    irq_id_t               claim_id;
    logic [NumTargets-1:0] complete_valid;
    irq_id_t               complete_id;
  } claim_t;

  typedef enum logic [2:0] {
    Idle,
    WriteSecond,
    ReadSecond,
    WriteResp,
    ReadResp
  } bridge_state_e;

endpackage

`default_nettype wire

// File: logic/plic_bridge_top.sv
`default_nettype none

module plic_bridge_top import plic_bridge_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  // AXI-lite slave
  input  wire logic      aw_valid_i,
  input  wire axil_aw_t  aw_i,
  output logic           aw_ready_o,
  input  wire logic      w_valid_i,
  input  wire axil_w_t   w_i,
  output logic           w_ready_o,
  output logic           b_valid_o,
  input  wire logic      b_ready_i,
  input  wire logic      ar_valid_i,
  input  wire axil_aw_t  ar_i,
  output logic           ar_ready_o,
  output logic           r_valid_o,
  output axi_data_t      r_data_o,
  input  wire logic      r_ready_i,
  // interrupt sources and lines
  input  wire src_vec_t  irq_sources_i,
  input  wire src_vec_t  irq_le_i,
  output logic [NumTargets-1:0] irq_o
);

  reg_req_t                  reg_req;
  reg_sel_t                  reg_sel;
  reg_data_t                 rdata;
  prio_t [NumSources-1:0]    prio;
  src_vec_t [NumTargets-1:0] enable;
  prio_t [NumTargets-1:0]    thresh;
  claim_t                    claim;
  src_vec_t                  pending;
  irq_id_t [NumTargets-1:0]  claim_id;

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  plic_bridge_fsm plic_bridge_fsm_inst (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .aw_valid_i ( aw_valid_i ),
    .aw_i       ( aw_i       ),
    .aw_ready_o ( aw_ready_o ),
    .w_valid_i  ( w_valid_i  ),
    .w_i        ( w_i        ),
    .w_ready_o  ( w_ready_o  ),
    .b_valid_o  ( b_valid_o  ),
    .b_ready_i  ( b_ready_i  ),
    .ar_valid_i ( ar_valid_i ),
    .ar_i       ( ar_i       ),
    .ar_ready_o ( ar_ready_o ),
    .r_valid_o  ( r_valid_o  ),
    .r_data_o   ( r_data_o   ),
    .r_ready_i  ( r_ready_i  ),
    .rdata_i    ( rdata      ),
    .reg_req_o  ( reg_req    )
  );

  plic_addr_map plic_addr_map_inst (
    .reg_req_i ( reg_req ),
    .reg_sel_o ( reg_sel )
  );

  ////////////////////////////////////////////////////////////
  // interrupt controller
  ////////////////////////////////////////////////////////////

  plic_reg_file plic_reg_file_inst (
    .clk_i      ( clk_i         ),
    .rst_ni     ( rst_ni        ),
    .reg_sel_i  ( reg_sel       ),
    .wdata_i    ( reg_req.wdata ),
    .rdata_o    ( rdata         ),
    .pending_i  ( pending       ),
    .claim_id_i ( claim_id      ),
    .prio_o     ( prio          ),
    .enable_o   ( enable        ),
    .thresh_o   ( thresh        ),
    .claim_o    ( claim         )
  );

  plic_gateway plic_gateway_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .irq_sources_i ( irq_sources_i ),
    .irq_le_i      ( irq_le_i      ),
    .claim_i       ( claim         ),
    .pending_o     ( pending       )
  );

  // target 0 machine, target 1 supervisor
  for (genvar t = 0; t < NumTargets; t++) begin : g_target
    plic_target plic_target_inst (
      .clk_i      ( clk_i       ),
      .rst_ni     ( rst_ni      ),
      .pending_i  ( pending     ),
      .enable_i   ( enable[t]   ),
      .prio_i     ( prio        ),
      .thresh_i   ( thresh[t]   ),
      .claim_id_o ( claim_id[t] ),
      .irq_o      ( irq_o[t]    )
    );
  end

endmodule

`default_nettype wire

// File: logic/plic_gateway.sv
`default_nettype none

module plic_gateway import plic_bridge_pkg::*; (
  input  wire logic     clk_i,
  input  wire logic     rst_ni,
  input  wire src_vec_t irq_sources_i,
  // 0 for level, 1 for edge
  input  wire src_vec_t irq_le_i,
  input  wire claim_t   claim_i,
  output src_vec_t      pending_o
);

  src_vec_t src_q;
  src_vec_t busy_q;
  src_vec_t pending_q;
  src_vec_t qualify;
  src_vec_t claim_hit;
  src_vec_t complete_hit;

  assign pending_o = pending_q;

  always_comb begin : p_qualify
    for (int unsigned i = 0; i < NumSources; i++) begin
      // rising edge against the delayed copy
      qualify[i] = irq_le_i[i] ? (irq_sources_i[i] && !src_q[i]) : irq_sources_i[i];
      claim_hit[i]    = (|claim_i.claim_valid) && (claim_i.claim_id == irq_id_t'(i));
      complete_hit[i] = (|claim_i.complete_valid) && (claim_i.complete_id == irq_id_t'(i));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_gate
    if (!rst_ni) begin
      src_q     <= '0;
      busy_q    <= '0;
      pending_q <= '0;
    end else begin
      src_q <= irq_sources_i;
      for (int unsigned i = 1; i < NumSources; i++) begin
        // claim closes the gate until complete
        if (claim_hit[i]) begin
          pending_q[i] <= 1'b0;
          busy_q[i]    <= 1'b1;
        end else if (qualify[i] && !busy_q[i]) begin
          pending_q[i] <= 1'b1;
        end
        if (complete_hit[i]) begin
          busy_q[i] <= 1'b0;
        end
      end
      // id 0 never pends
      pending_q[0] <= 1'b0;
      busy_q[0]    <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/plic_reg_file.sv
`default_nettype none

module plic_reg_file import plic_bridge_pkg::*; (
  input  wire logic                       clk_i,
  input  wire logic                       rst_ni,
  input  wire reg_sel_t                   reg_sel_i,
  input  wire reg_data_t                  wdata_i,
  output reg_data_t                       rdata_o,
  input  wire src_vec_t                   pending_i,
  input  wire irq_id_t [NumTargets-1:0]   claim_id_i,
  output prio_t [NumSources-1:0]          prio_o,
  output src_vec_t [NumTargets-1:0]       enable_o,
  output prio_t [NumTargets-1:0]          thresh_o,
  output claim_t                          claim_o
);

  prio_t [NumSources-1:0]    prio_q;
  src_vec_t [NumTargets-1:0] enable_q;
  prio_t [NumTargets-1:0]    thresh_q;

  assign prio_o   = prio_q;
  assign enable_o = enable_q;
  assign thresh_o = thresh_q;

  ////////////////////////////////////////////////////////////
  // configuration registers
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cfg
    if (!rst_ni) begin
      prio_q   <= '0;
      enable_q <= '0;
      thresh_q <= '0;
    end else if (reg_sel_i.we) begin
      case (reg_sel_i.kind)
        KindPrio: begin
          // source 0 is reserved and keeps priority 0
          if (reg_sel_i.src != '0) begin
            prio_q[reg_sel_i.src] <= wdata_i[PrioWidth-1:0];
          end
        end
        KindEnable: begin
          enable_q[reg_sel_i.tgt] <= {wdata_i[NumSources-1:1], 1'b0};
        end
        KindThresh: begin
          thresh_q[reg_sel_i.tgt] <= wdata_i[PrioWidth-1:0];
        end
        default: begin
          // pending is read only, claim handled below
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////

  always_comb begin : p_rdata
    rdata_o = '0;
    case (reg_sel_i.kind)
      KindPrio:   rdata_o = RegWidth'(prio_q[reg_sel_i.src]);
      KindPend:   rdata_o = RegWidth'(pending_i);
      KindEnable: rdata_o = RegWidth'(enable_q[reg_sel_i.tgt]);
      KindThresh: rdata_o = RegWidth'(thresh_q[reg_sel_i.tgt]);
      KindClaim:  rdata_o = RegWidth'(claim_id_i[reg_sel_i.tgt]);
      default:    rdata_o = '0;
    endcase
  end

  // claim on read, complete on write
  always_comb begin : p_claim
    claim_o.claim_valid    = '0;
    claim_o.complete_valid = '0;
    claim_o.claim_id       = claim_id_i[reg_sel_i.tgt];
    claim_o.complete_id    = wdata_i[IdWidth-1:0];
    if (reg_sel_i.kind == KindClaim) begin
      claim_o.claim_valid[reg_sel_i.tgt]    = reg_sel_i.re;
      claim_o.complete_valid[reg_sel_i.tgt] = reg_sel_i.we;
    end
  end

endmodule

`default_nettype wire

// File: logic/plic_target.sv
`default_nettype none

module plic_target import plic_bridge_pkg::*; (
  input  wire logic                   clk_i,
  input  wire logic                   rst_ni,
  input  wire src_vec_t               pending_i,
  input  wire src_vec_t               enable_i,
  input  wire prio_t [NumSources-1:0] prio_i,
  input  wire prio_t                  thresh_i,
  output irq_id_t                     claim_id_o,
  output logic                        irq_o
);

  prio_t   best_prio;
  irq_id_t best_id;
  logic    irq_q;

  // strict compare keeps the lowest id on a tie
  // priority 0 never wins
  always_comb begin : p_select
    best_prio = '0;
    best_id   = '0;
    for (int unsigned i = 1; i < NumSources; i++) begin
      if (pending_i[i] && enable_i[i] && (prio_i[i] > best_prio)) begin
        best_prio = prio_i[i];
        best_id   = irq_id_t'(i);
      end
    end
  end

  assign claim_id_o = (best_prio > thresh_i) ? best_id : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_irq
    if (!rst_ni) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= (claim_id_o != '0);
    end
  end

  assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: plic_bridge.f
logic/plic_bridge_pkg.sv
logic/plic_addr_map.sv
logic/plic_bridge_fsm.sv
logic/plic_reg_file.sv
logic/plic_gateway.sv
logic/plic_target.sv
logic/plic_bridge_top.sv
verification/plic_bridge_tb.sv

// File: verification/plic_bridge_tb.sv
`default_nettype none

module plic_bridge_tb import plic_bridge_pkg::*; ();

  localparam int unsigned Timeout  = 200;
  localparam axi_size_t   SizeWord = 3'd2;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  aw_valid_i;
  axil_aw_t              aw_i;
  logic                  aw_ready_o;
  logic                  w_valid_i;
  axil_w_t               w_i;
  logic                  w_ready_o;
  logic                  b_valid_o;
  logic                  b_ready_i;
  logic                  ar_valid_i;
  axil_aw_t              ar_i;
  logic                  ar_ready_o;
  logic                  r_valid_o;
  axi_data_t             r_data_o;
  logic                  r_ready_i;
  src_vec_t              irq_sources_i;
  src_vec_t              irq_le_i;
  logic [NumTargets-1:0] irq_o;

  integer      seed = 32'h0b29_4578;
  int unsigned checks = 0;
  int unsigned errors = 0;

  plic_bridge_top plic_bridge_top_inst (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .aw_valid_i    ( aw_valid_i    ),
    .aw_i          ( aw_i          ),
    .aw_ready_o    ( aw_ready_o    ),
    .w_valid_i     ( w_valid_i     ),
    .w_i           ( w_i           ),
    .w_ready_o     ( w_ready_o     ),
    .b_valid_o     ( b_valid_o     ),
    .b_ready_i     ( b_ready_i     ),
    .ar_valid_i    ( ar_valid_i    ),
    .ar_i          ( ar_i          ),
    .ar_ready_o    ( ar_ready_o    ),
    .r_valid_o     ( r_valid_o     ),
    .r_data_o      ( r_data_o      ),
    .r_ready_i     ( r_ready_i     ),
    .irq_sources_i ( irq_sources_i ),
    .irq_le_i      ( irq_le_i      ),
    .irq_o         ( irq_o         )
  );

  initial begin : p_clock
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // address map and reporting helpers
  ////////////////////////////////////////////////////////////

  function automatic axi_addr_t prio_addr(input int unsigned src);
    return PlicBase + PrioOffset + PrioStride * src;
  endfunction

  function automatic axi_addr_t pend_addr();
    return PlicBase + PendOffset;
  endfunction

  function automatic axi_addr_t enable_addr(input int unsigned tgt);
    return PlicBase + EnableOffset + EnableStride * tgt;
  endfunction

  function automatic axi_addr_t thresh_addr(input int unsigned tgt);
    return PlicBase + ThreshOffset + ThreshStride * tgt;
  endfunction

  function automatic axi_addr_t claim_addr(input int unsigned tgt);
    return PlicBase + ClaimOffset + ThreshStride * tgt;
  endfunction

  // a priority register keeps only its low 3 bits
  function automatic reg_data_t prio_word(input reg_data_t data);
    return {29'h0, data[2:0]};
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
    end
  endtask

  task automatic finish_run();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic timeout_fail(input string what);
    errors++;
    $display("Timeout at %0t: the DUT never showed %s", $time, what);
    finish_run();
  endtask

  ////////////////////////////////////////////////////////////
  // bus and interrupt tasks
  ////////////////////////////////////////////////////////////

  task automatic axil_write(input axi_addr_t addr, input axi_data_t data,
                            input axi_size_t size);
    int unsigned cnt;
    cnt = 0;
    @(posedge clk_i);
    aw_valid_i <= 1'b1;
    aw_i.addr  <= addr;
    aw_i.size  <= size;
    w_valid_i  <= 1'b1;
    w_i.data   <= data;
    w_i.strb   <= '1;
    @(negedge clk_i);
    while (!(aw_ready_o && w_ready_o)) begin
      cnt++;
      if (cnt >= Timeout) begin
        timeout_fail("write address and data ready");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    aw_valid_i <= 1'b0;
    w_valid_i  <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!b_valid_o) begin
      cnt++;
      if (cnt >= Timeout) begin
        timeout_fail("a write response");
      end
      @(negedge clk_i);
    end
    // b_ready_i is high, response taken at this edge
    @(posedge clk_i);
  endtask

  task automatic axil_read(input axi_addr_t addr, input axi_size_t size,
                           input axi_data_t expected, input int unsigned stall);
    int unsigned cnt;
    int unsigned i;
    axi_data_t   held;
    axi_data_t   mask;
    cnt  = 0;
    // a 32-bit read only defines the low word
    mask = (size == SizeDword) ? '1 : 64'h0000_0000_ffff_ffff;
    @(posedge clk_i);
    ar_valid_i <= 1'b1;
    ar_i.addr  <= addr;
    ar_i.size  <= size;
    r_ready_i  <= (stall == 0);
    @(negedge clk_i);
    while (!ar_ready_o) begin
      cnt++;
      if (cnt >= Timeout) begin
        timeout_fail("read address ready");
      end
      @(negedge clk_i);
    end
    @(posedge clk_i);
    ar_valid_i <= 1'b0;
    cnt = 0;
    @(negedge clk_i);
    while (!r_valid_o) begin
      cnt++;
      if (cnt >= Timeout) begin
        timeout_fail("read data valid");
      end
      @(negedge clk_i);
    end
    held = r_data_o;
    if (stall != 0) begin
      // response has to hold while r_ready_i is low
      for (i = 0; i < stall; i++) begin
        @(negedge clk_i);
        check_value("r_valid_o", r_valid_o, 1'b1);
        check_value("r_data_o", r_data_o, held);
      end
      @(posedge clk_i);
      r_ready_i <= 1'b1;
      @(negedge clk_i);
    end
    check_value("r_data_o", r_data_o & mask, expected);
    @(posedge clk_i);
  endtask

  task automatic wait_irq(input int unsigned tgt, input logic level);
    int unsigned cnt;
    cnt = 0;
    @(negedge clk_i);
    while (irq_o[tgt] !== level) begin
      cnt++;
      if (cnt >= Timeout) begin
        timeout_fail($sformatf("irq_o[%0d] at level %0b", tgt, level));
      end
      @(negedge clk_i);
    end
  endtask

  task automatic check_irq_quiet(input int unsigned tgt, input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk_i);
      check_value($sformatf("irq_o[%0d]", tgt), irq_o[tgt], 1'b0);
    end
  endtask

  task automatic pulse_source(input int unsigned src);
    @(posedge clk_i);
    irq_sources_i[src] <= 1'b1;
    @(posedge clk_i);
    irq_sources_i[src] <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    @(negedge clk_i);
    check_value("irq_o", irq_o, '0);
    check_value("b_valid_o", b_valid_o, 1'b0);
    check_value("r_valid_o", r_valid_o, 1'b0);
    check_value("aw_ready_o", aw_ready_o, 1'b1);
    check_value("w_ready_o", w_ready_o, 1'b1);
    check_value("ar_ready_o", ar_ready_o, 1'b1);
  endtask

  task automatic test_priority_access();
    reg_data_t d0;
    reg_data_t d1;
    reg_data_t d2;
    d0 = $random(seed);
    d1 = $random(seed);
    d2 = $random(seed);
    axil_write(prio_addr(3), {32'h0, d0}, SizeWord);
    axil_read(prio_addr(3), SizeWord, {32'h0, prio_word(d0)}, 0);
    // low word to source 4, high word to source 5
    axil_write(prio_addr(4), {d2, d1}, SizeDword);
    axil_read(prio_addr(4), SizeDword, {prio_word(d2), prio_word(d1)}, 0);
    axil_write(prio_addr(0), {32'h0, d0 | 32'h7}, SizeWord);
    axil_read(prio_addr(0), SizeWord, 64'h0, 0);
  endtask

  task automatic test_level_source();
    axil_write(prio_addr(2), 64'd5, SizeWord);
    axil_write(enable_addr(0), 64'h4, SizeWord);
    axil_write(thresh_addr(0), 64'd0, SizeWord);
    @(posedge clk_i);
    irq_sources_i[2] <= 1'b1;
    wait_irq(0, 1'b1);
    axil_read(claim_addr(0), SizeWord, 64'd2, 0);
    wait_irq(0, 1'b0);
    axil_read(pend_addr(), SizeWord, 64'h0, 0);
    // source still high, so complete re-arms it
    axil_write(claim_addr(0), 64'd2, SizeWord);
    wait_irq(0, 1'b1);
    @(posedge clk_i);
    irq_sources_i[2] <= 1'b0;
    axil_read(claim_addr(0), SizeWord, 64'd2, 0);
    axil_write(claim_addr(0), 64'd2, SizeWord);
    axil_write(enable_addr(0), 64'h0, SizeWord);
    wait_irq(0, 1'b0);
  endtask

  task automatic test_edge_threshold();
    @(posedge clk_i);
    irq_le_i[3] <= 1'b1;
    axil_write(prio_addr(3), 64'd4, SizeWord);
    axil_write(enable_addr(0), 64'h8, SizeWord);
    // source stays high, only its rising edge may pend
    @(posedge clk_i);
    irq_sources_i[3] <= 1'b1;
    wait_irq(0, 1'b1);
    axil_read(claim_addr(0), SizeWord, 64'd3, 0);
    axil_write(claim_addr(0), 64'd3, SizeWord);
    check_irq_quiet(0, 8);
    @(posedge clk_i);
    irq_sources_i[3] <= 1'b0;
    // threshold equal to the priority blocks target 1
    axil_write(enable_addr(0), 64'h0, SizeWord);
    axil_write(enable_addr(1), 64'h8, SizeWord);
    axil_write(thresh_addr(1), 64'd4, SizeWord);
    pulse_source(3);
    axil_read(pend_addr(), SizeWord, 64'h8, 0);
    check_irq_quiet(1, 8);
    axil_write(thresh_addr(1), 64'd3, SizeWord);
    wait_irq(1, 1'b1);
    axil_read(claim_addr(1), SizeWord, 64'd3, 0);
    axil_write(claim_addr(1), 64'd3, SizeWord);
    axil_write(enable_addr(1), 64'h0, SizeWord);
    axil_write(thresh_addr(1), 64'd0, SizeWord);
    wait_irq(1, 1'b0);
  endtask

  task automatic test_priority_select();
    axil_write(prio_addr(1), 64'd2, SizeWord);
    axil_write(prio_addr(6), 64'd6, SizeWord);
    axil_write(enable_addr(0), 64'h42, SizeWord);
    @(posedge clk_i);
    irq_sources_i[1] <= 1'b1;
    irq_sources_i[6] <= 1'b1;
    wait_irq(0, 1'b1);
    axil_read(pend_addr(), SizeWord, 64'h42, 0);
    axil_read(claim_addr(0), SizeWord, 64'd6, 0);
    // source 6 pends again, both stay pending for the next test
    axil_write(claim_addr(0), 64'd6, SizeWord);
  endtask

  task automatic test_back_pressure();
    @(posedge clk_i);
    irq_sources_i[1] <= 1'b0;
    irq_sources_i[6] <= 1'b0;
    // threshold in the low word, claim of target 0 in the high word
    axil_read(thresh_addr(0), SizeDword, {32'd6, 32'd0}, 5);
    axil_read(claim_addr(0), SizeWord, 64'd1, 0);
    axil_read(pend_addr(), SizeWord, 64'h0, 0);
    axil_write(claim_addr(0), 64'd6, SizeWord);
    axil_write(claim_addr(0), 64'd1, SizeWord);
    wait_irq(0, 1'b0);
  endtask

  initial begin : p_main
    rst_ni        <= 1'b0;
    aw_valid_i    <= 1'b0;
    aw_i          <= '0;
    w_valid_i     <= 1'b0;
    w_i           <= '0;
    b_ready_i     <= 1'b1;
    ar_valid_i    <= 1'b0;
    ar_i          <= '0;
    r_ready_i     <= 1'b1;
    irq_sources_i <= '0;
    irq_le_i      <= '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    test_reset();
    test_priority_access();
    test_level_source();
    test_edge_threshold();
    test_priority_select();
    test_back_pressure();
    finish_run();
  end

endmodule

`default_nettype wire
